//--- hdl/alu.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module alu (
    input  rv_ctrl_pkg::alu_ctrl_t  ctrl_i,
    input  logic [`RV_XLEN-1:0]     src1_i,
    input  logic [`RV_XLEN-1:0]     src2_i,
    output logic [`RV_XLEN-1:0]     rslt_o
);

    logic [`RV_XLEN+1:0]        add_a;
    logic [`RV_XLEN+1:0]        add_b;
    logic [`RV_XLEN+1:0]        add_sum;
    logic                       less;
    logic [`RV_SHAMT_W-1:0]     shamt;
    logic signed [`RV_XLEN:0]   sra_src;
    logic [`RV_XLEN:0]          sra_full;
    logic [`RV_XLEN-1:0]        add_rslt;
    logic [`RV_XLEN-1:0]        shl_rslt;
    logic [`RV_XLEN-1:0]        shr_rslt;
    logic [`RV_XLEN-1:0]        logic_rslt;
    logic [`RV_XLEN-1:0]        pass_rslt;

    // extra lsb carries the +1 of the two's complement
    assign add_a   = {ctrl_i.is_signed & src1_i[`RV_XLEN-1], src1_i, 1'b1};
    assign add_b   = {ctrl_i.is_signed & src2_i[`RV_XLEN-1], src2_i, 1'b0} ^
                     {(`RV_XLEN+2){ctrl_i.is_neg}};
    assign add_sum = add_a + add_b;
    assign less    = ctrl_i.is_less & add_sum[`RV_XLEN+1];  // sign of a - b
    assign add_rslt = ctrl_i.is_add ? add_sum[`RV_XLEN:1] : '0;

    // --------------------
    // shifter
    assign shamt    = src2_i[`RV_SHAMT_W-1:0];
    assign sra_src  = {ctrl_i.is_signed & src1_i[`RV_XLEN-1], src1_i};
    assign sra_full = sra_src >>> shamt;
    assign shl_rslt = ctrl_i.shift_left ? (src1_i << shamt) : '0;
    assign shr_rslt = ctrl_i.shift_right ? sra_full[`RV_XLEN-1:0] : '0;

    // or = xor | and
    assign logic_rslt = (ctrl_i.xor_or ? (src1_i ^ src2_i) : '0) |
                        (ctrl_i.or_and ? (src1_i & src2_i) : '0);
    assign pass_rslt  = ctrl_i.pass_src2 ? src2_i : '0;

    assign rslt_o = {{(`RV_XLEN-1){1'b0}}, less} | add_rslt | shl_rslt | shr_rslt |
                    logic_rslt | pass_rslt;

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module decode_stage (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          in_valid_i,
    input  logic                          hold_i,
    input  logic [31:0]                   instr_i,
    input  logic [`RV_XLEN-1:0]           rs1_val_i,
    input  logic [`RV_XLEN-1:0]           rs2_val_i,
    output logic                          in_ready_o,
    output logic                          valid_o,
    output logic [`RV_REG_ADDR_W-1:0]     rd_o,
    output logic [`RV_XLEN-1:0]           src1_o,
    output logic [`RV_XLEN-1:0]           src2_o,
    output rv_ctrl_pkg::alu_ctrl_t        alu_ctrl_o,
    output rv_ctrl_pkg::mul_ctrl_t        mul_ctrl_o,
    output rv_ctrl_pkg::div_ctrl_t        div_ctrl_o
);

    rv_isa_pkg::opcode_e            opc;
    logic [2:0]                     f3;
    logic [6:0]                     f7;
    logic                           is_op;
    logic                           is_imm;
    logic                           is_lui;
    logic                           is_m;
    logic                           is_arith;
    logic                           is_alt;
    logic                           accept;
    logic [`RV_XLEN-1:0]            imm_i_type;
    logic [`RV_XLEN-1:0]            imm_u_type;
    logic [`RV_XLEN-1:0]            src2_d;
    logic [`RV_REG_ADDR_W-1:0]      rd_d;
    rv_ctrl_pkg::alu_ctrl_t         alu_d;
    rv_ctrl_pkg::mul_ctrl_t         mul_d;
    rv_ctrl_pkg::div_ctrl_t         div_d;

    assign in_ready_o = ~hold_i;
    assign accept     = in_valid_i & in_ready_o;

    // --------------------
    // field decode
    assign opc = rv_isa_pkg::opcode_e'(instr_i[6:2]);
    assign f3  = instr_i[14:12];
    assign f7  = instr_i[31:25];

    assign is_op    = (opc == rv_isa_pkg::OPC_OP);
    assign is_imm   = (opc == rv_isa_pkg::OPC_OP_IMM);
    assign is_lui   = (opc == rv_isa_pkg::OPC_LUI);
    assign is_m     = is_op & (f7 == rv_isa_pkg::FUNCT7_MULDIV);
    assign is_arith = is_imm | (is_op & ~is_m);
    assign is_alt   = (f7 == rv_isa_pkg::FUNCT7_ALT);  // imm[11:5] for srai

    always_comb begin
        alu_d             = '0;
        alu_d.is_signed   = is_arith & ((f3 == rv_isa_pkg::F3_SLT) |
                            ((f3 == rv_isa_pkg::F3_SRL_SRA) & is_alt));
        alu_d.is_less     = is_arith & ((f3 == rv_isa_pkg::F3_SLT) |
                            (f3 == rv_isa_pkg::F3_SLTU));
        alu_d.is_neg      = alu_d.is_less | (is_op & ~is_m & is_alt &
                            (f3 == rv_isa_pkg::F3_ADD_SUB));  // sub only from OP
        alu_d.is_add      = is_arith & (f3 == rv_isa_pkg::F3_ADD_SUB);
        alu_d.shift_left  = is_arith & (f3 == rv_isa_pkg::F3_SLL);
        alu_d.shift_right = is_arith & (f3 == rv_isa_pkg::F3_SRL_SRA);
        alu_d.xor_or      = is_arith & ((f3 == rv_isa_pkg::F3_XOR) |
                            (f3 == rv_isa_pkg::F3_OR));
        alu_d.or_and      = is_arith & ((f3 == rv_isa_pkg::F3_OR) |
                            (f3 == rv_isa_pkg::F3_AND));
        alu_d.pass_src2   = is_lui;
    end

    // funct3 bit 2 splits multiply from divide
    always_comb begin
        mul_d             = '0;
        mul_d.is_mul      = is_m & ~f3[2];
        mul_d.src1_signed = is_m & ((f3 == rv_isa_pkg::F3_MULH) |
                            (f3 == rv_isa_pkg::F3_MULHSU));
        mul_d.src2_signed = is_m & (f3 == rv_isa_pkg::F3_MULH);
        mul_d.is_high     = mul_d.is_mul & (f3 != rv_isa_pkg::F3_MUL);
        div_d             = '0;
        div_d.is_div      = is_m & f3[2];
        div_d.is_signed   = is_m & ((f3 == rv_isa_pkg::F3_DIV) |
                            (f3 == rv_isa_pkg::F3_REM));
        div_d.is_rem      = is_m & ((f3 == rv_isa_pkg::F3_REM) |
                            (f3 == rv_isa_pkg::F3_REMU));
    end

    // --------------------
    // operand select
    assign imm_i_type = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u_type = {instr_i[31:12], {(`RV_XLEN-20){1'b0}}};
    assign src2_d = is_imm ? imm_i_type : (is_lui ? imm_u_type : rs2_val_i);
    assign rd_d   = (is_op | is_imm | is_lui) ? instr_i[7 +: `RV_REG_ADDR_W] : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (!hold_i) begin
            valid_o <= in_valid_i;  // empty slot when nothing issued
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rd_o       <= rd_d;
            src1_o     <= rs1_val_i;
            src2_o     <= src2_d;
            alu_ctrl_o <= alu_d;
            mul_ctrl_o <= mul_d;
            div_ctrl_o <= div_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/divider.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module divider (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  rv_ctrl_pkg::div_ctrl_t  ctrl_i,
    input  logic [`RV_XLEN-1:0]     src1_i,
    input  logic [`RV_XLEN-1:0]     src2_i,
    output logic                    done_o,
    output logic [`RV_XLEN-1:0]     rslt_o
);

    localparam int CNT_W = $clog2(`RV_DIV_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`RV_DIV_STEPS - 1);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CHECK,
        DIV_EXEC,
        DIV_RET
    } div_state_e;

    div_state_e             state;
    logic [CNT_W-1:0]       cnt;
    logic [`RV_XLEN-1:0]    rem_r;
    logic [`RV_XLEN-1:0]    quo_r;  // dividend shifts out, quotient in
    logic [`RV_XLEN-1:0]    dvsr_r;
    logic                   q_neg;
    logic                   r_neg;
    logic                   is_rem;
    logic                   s1_neg;
    logic                   s2_neg;
    logic [`RV_XLEN:0]      trial;
    logic                   fits;

    assign s1_neg = ctrl_i.is_signed & src1_i[`RV_XLEN-1];
    assign s2_neg = ctrl_i.is_signed & src2_i[`RV_XLEN-1];

    // shifted partial remainder minus divisor
    assign trial = {rem_r, quo_r[`RV_XLEN-1]} - {1'b0, dvsr_r};
    assign fits  = ~trial[`RV_XLEN];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE:  if (start_i) state <= DIV_CHECK;
                DIV_CHECK: state <= (dvsr_r == '0) ? DIV_RET : DIV_EXEC;  // div by zero
                DIV_EXEC:  if (cnt == LAST_STEP) state <= DIV_RET;
                default:   state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state)
            DIV_IDLE: begin
                if (start_i) begin
                    rem_r  <= src1_i;  // kept as is for rem by zero
                    quo_r  <= s1_neg ? -src1_i : src1_i;
                    dvsr_r <= s2_neg ? -src2_i : src2_i;
                    q_neg  <= s1_neg ^ s2_neg;
                    r_neg  <= s1_neg;
                    is_rem <= ctrl_i.is_rem;
                end
            end
            DIV_CHECK: begin
                cnt <= '0;
                if (dvsr_r == '0) begin
                    quo_r <= '1;
                    q_neg <= 1'b0;
                    r_neg <= 1'b0;
                end else begin
                    rem_r <= '0;
                end
            end
            DIV_EXEC: begin
                cnt   <= cnt + 1'b1;
                quo_r <= {quo_r[`RV_XLEN-2:0], fits};
                rem_r <= fits ? trial[`RV_XLEN-1:0] : {rem_r[`RV_XLEN-2:0], quo_r[`RV_XLEN-1]};
            end
            default: ;
        endcase
    end

    // --------------------
    // sign fix-up on the way out
    assign done_o = (state == DIV_RET);
    assign rslt_o = !done_o ? '0 :
                    is_rem  ? (r_neg ? -rem_r : rem_r) :
                              (q_neg ? -quo_r : quo_r);

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module execute_stage (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        valid_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rd_i,
    input  logic [`RV_XLEN-1:0]         src1_i,
    input  logic [`RV_XLEN-1:0]         src2_i,
    input  rv_ctrl_pkg::alu_ctrl_t      alu_ctrl_i,
    input  rv_ctrl_pkg::mul_ctrl_t      mul_ctrl_i,
    input  rv_ctrl_pkg::div_ctrl_t      div_ctrl_i,
    output logic                        hold_o,
    output logic                        out_valid_o,
    output logic [`RV_REG_ADDR_W-1:0]   out_rd_o,
    output logic [`RV_XLEN-1:0]         out_data_o
);

    logic                   needs_unit;
    logic                   unit_busy;
    logic                   start;
    logic                   unit_done;
    logic                   finish;
    logic                   mul_done;
    logic                   div_done;
    logic [`RV_XLEN-1:0]    alu_rslt;
    logic [`RV_XLEN-1:0]    mul_rslt;
    logic [`RV_XLEN-1:0]    div_rslt;

    alu u_alu (
        .ctrl_i (alu_ctrl_i),
        .src1_i (src1_i),
        .src2_i (src2_i),
        .rslt_o (alu_rslt)
    );

    multiplier u_mul (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (start & mul_ctrl_i.is_mul),
        .ctrl_i  (mul_ctrl_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .done_o  (mul_done),
        .rslt_o  (mul_rslt)
    );

    divider u_div (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (start & div_ctrl_i.is_div),
        .ctrl_i  (div_ctrl_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .done_o  (div_done),
        .rslt_o  (div_rslt)
    );

    // --------------------
    // stall control
    assign needs_unit = mul_ctrl_i.is_mul | div_ctrl_i.is_div;
    assign start      = valid_i & ~unit_busy;  // first cycle of this entry only
    assign unit_done  = mul_done | div_done;
    assign hold_o     = valid_i & needs_unit & ~unit_done;
    assign finish     = valid_i & (~needs_unit | unit_done);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            unit_busy   <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= finish;
            if (start & needs_unit) begin
                unit_busy <= 1'b1;
            end else if (unit_done) begin
                unit_busy <= 1'b0;
            end
        end
    end

    // idle units drive zero, so or merges
    always_ff @(posedge clk_i) begin
        if (finish) begin
            out_rd_o   <= rd_i;
            out_data_o <= alu_rslt | mul_rslt | div_rslt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/multiplier.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module multiplier (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  rv_ctrl_pkg::mul_ctrl_t  ctrl_i,
    input  logic [`RV_XLEN-1:0]     src1_i,
    input  logic [`RV_XLEN-1:0]     src2_i,
    output logic                    done_o,
    output logic [`RV_XLEN-1:0]     rslt_o
);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_EXEC,
        MUL_RET
    } mul_state_e;

    mul_state_e                 state;
    logic signed [`RV_XLEN:0]   op_a;  // sign or zero extended
    logic signed [`RV_XLEN:0]   op_b;
    logic [2*`RV_XLEN-1:0]      product;
    logic                       is_high;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: if (start_i) state <= MUL_EXEC;
                MUL_EXEC: state <= MUL_RET;
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == MUL_IDLE && start_i) begin
            op_a    <= {ctrl_i.src1_signed & src1_i[`RV_XLEN-1], src1_i};
            op_b    <= {ctrl_i.src2_signed & src2_i[`RV_XLEN-1], src2_i};
            is_high <= ctrl_i.is_high;
        end
        if (state == MUL_EXEC) begin
            product <= op_a * op_b;  // low 2*xlen bits of the signed product
        end
    end

    assign done_o = (state == MUL_RET);
    assign rslt_o = !done_o ? '0 :
                    (is_high ? product[2*`RV_XLEN-1:`RV_XLEN] : product[`RV_XLEN-1:0]);

endmodule

`default_nettype wire

//--- hdl/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // alu control word, one bit per datapath
    typedef struct packed {
        logic is_signed;    // slt, sra
        logic is_neg;       // invert src2 for sub and compare
        logic is_less;      // result is the compare bit
        logic is_add;       // result is the sum
        logic shift_left;
        logic shift_right;
        logic xor_or;
        logic or_and;
        logic pass_src2;    // lui
    } alu_ctrl_t;

    typedef struct packed {
        logic is_mul;
        logic src1_signed;
        logic src2_signed;
        logic is_high;      // return upper half
    } mul_ctrl_t;

    typedef struct packed {
        logic is_div;
        logic is_signed;
        logic is_rem;       // return remainder
    } div_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/rv_exec_params.svh
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

`define RV_XLEN        32  // data width
`define RV_REG_ADDR_W  5   // register number width
`define RV_SHAMT_W     5   // shift amount width
`define RV_DIV_STEPS   32  // divider iterations, one quotient bit each

`endif

//--- hdl/rv_exec_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_exec_unit (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        in_valid_i,
    input  logic [31:0]                 instr_i,
    input  logic [`RV_XLEN-1:0]         rs1_val_i,
    input  logic [`RV_XLEN-1:0]         rs2_val_i,
    output logic                        in_ready_o,
    output logic                        out_valid_o,
    output logic [`RV_REG_ADDR_W-1:0]   out_rd_o,
    output logic [`RV_XLEN-1:0]         out_data_o
);

    logic                           dec_valid;
    logic [`RV_REG_ADDR_W-1:0]      dec_rd;
    logic [`RV_XLEN-1:0]            dec_src1;
    logic [`RV_XLEN-1:0]            dec_src2;
    rv_ctrl_pkg::alu_ctrl_t         dec_alu_ctrl;
    rv_ctrl_pkg::mul_ctrl_t         dec_mul_ctrl;
    rv_ctrl_pkg::div_ctrl_t         dec_div_ctrl;
    logic                           exec_hold;  // mul or div in progress

    decode_stage u_decode (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_valid_i (in_valid_i),
        .hold_i     (exec_hold),
        .instr_i    (instr_i),
        .rs1_val_i  (rs1_val_i),
        .rs2_val_i  (rs2_val_i),
        .in_ready_o (in_ready_o),
        .valid_o    (dec_valid),
        .rd_o       (dec_rd),
        .src1_o     (dec_src1),
        .src2_o     (dec_src2),
        .alu_ctrl_o (dec_alu_ctrl),
        .mul_ctrl_o (dec_mul_ctrl),
        .div_ctrl_o (dec_div_ctrl)
    );

    execute_stage u_execute (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (dec_valid),
        .rd_i        (dec_rd),
        .src1_i      (dec_src1),
        .src2_i      (dec_src2),
        .alu_ctrl_i  (dec_alu_ctrl),
        .mul_ctrl_i  (dec_mul_ctrl),
        .div_ctrl_i  (dec_div_ctrl),
        .hold_o      (exec_hold),
        .out_valid_o (out_valid_o),
        .out_rd_o    (out_rd_o),
        .out_data_o  (out_data_o)
    );

endmodule

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,  // not executed here
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101
    } opcode_e;

    // --------------------
    // funct3, base integer ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // --------------------
    // funct3, M extension
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub, sra, srai

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv_exec_tb -f rv_exec.f -o rv_exec_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/rv_exec_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

//--- rv_exec.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/alu.sv
hdl/multiplier.sv
hdl/divider.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/rv_exec_unit.sv
verif/rv_exec_tb.sv

//--- verif/rv_exec_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_exec_tb;

    localparam int          NUM_INSTR  = 400;
    localparam int          MAX_CYCLES = 40 * NUM_INSTR + 100;
    localparam logic [31:0] LFSR_SEED  = 32'd32125;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    logic                           clk_i;
    logic                           rst_i;
    logic                           in_valid_i;
    logic [31:0]                    instr_i;
    logic [`RV_XLEN-1:0]            rs1_val_i;
    logic [`RV_XLEN-1:0]            rs2_val_i;
    logic                           in_ready_o;
    logic                           out_valid_o;
    logic [`RV_REG_ADDR_W-1:0]      out_rd_o;
    logic [`RV_XLEN-1:0]            out_data_o;

    logic [31:0]    lfsr_state;
    logic [4:0]     exp_rd_q[$];
    logic [31:0]    exp_data_q[$];
    logic           took;
    int             n_accepted;
    int             div_count;
    int             cycle_count = 0;

    rv_exec_unit uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .instr_i     (instr_i),
        .rs1_val_i   (rs1_val_i),
        .rs2_val_i   (rs2_val_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_rd_o    (out_rd_o),
        .out_data_o  (out_data_o)
    );

    always #20 clk_i = ~clk_i;

    // --------------------
    // random source
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
        end
        return bits;
    endfunction

    // --------------------
    // reference model
    function automatic logic [31:0] model_muldiv(input logic [2:0] f3, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [63:0]        prod;
        sa = a;
        sb = b;
        case (f3)
            rv_isa_pkg::F3_MUL: return a * b;
            rv_isa_pkg::F3_MULH: begin
                prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // exact mod 2^64
                return prod[63:32];
            end
            rv_isa_pkg::F3_MULHSU: begin
                prod = {{32{a[31]}}, a} * {32'h0, b};
                return prod[63:32];
            end
            rv_isa_pkg::F3_MULHU: begin
                prod = {32'h0, a} * {32'h0, b};
                return prod[63:32];
            end
            rv_isa_pkg::F3_DIV: begin
                if (b == '0) return '1;
                if (a == 32'h8000_0000 && b == '1) return a;  // signed overflow
                return sa / sb;
            end
            rv_isa_pkg::F3_DIVU: return (b == '0) ? '1 : a / b;
            rv_isa_pkg::F3_REM: begin
                if (b == '0) return a;
                if (a == 32'h8000_0000 && b == '1) return '0;
                return sa % sb;
            end
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] instr, input logic [31:0] a,
                                                 input logic [31:0] rs2);
        logic [4:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               alt;
        opc = instr[6:2];
        f3  = instr[14:12];
        f7  = instr[31:25];
        alt = (f7 == rv_isa_pkg::FUNCT7_ALT);
        b   = (opc == rv_isa_pkg::OPC_OP_IMM) ? {{20{instr[31]}}, instr[31:20]} : rs2;
        sa  = a;
        sb  = b;
        if (opc == rv_isa_pkg::OPC_LUI) return {instr[31:12], 12'h000};
        if (opc != rv_isa_pkg::OPC_OP && opc != rv_isa_pkg::OPC_OP_IMM) return '0;
        if (opc == rv_isa_pkg::OPC_OP && f7 == rv_isa_pkg::FUNCT7_MULDIV) begin
            return model_muldiv(f3, a, b);
        end
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: begin
                if (alt && opc == rv_isa_pkg::OPC_OP) return a - b;
                return a + b;
            end
            rv_isa_pkg::F3_SLL:  return a << b[4:0];
            rv_isa_pkg::F3_SLT:  return {31'h0, sa < sb};
            rv_isa_pkg::F3_SLTU: return {31'h0, a < b};
            rv_isa_pkg::F3_XOR:  return a ^ b;
            rv_isa_pkg::F3_SRL_SRA: begin
                if (alt) return sa >>> b[4:0];
                return a >> b[4:0];
            end
            rv_isa_pkg::F3_OR:   return a | b;
            default:             return a & b;
        endcase
    endfunction

    function automatic logic [4:0] model_rd(input logic [31:0] instr);
        if (instr[6:2] == rv_isa_pkg::OPC_OP || instr[6:2] == rv_isa_pkg::OPC_OP_IMM ||
            instr[6:2] == rv_isa_pkg::OPC_LUI) begin
            return instr[11:7];
        end
        return '0;  // unsupported opcode
    endfunction

    // --------------------
    // stimulus and checks
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic make_instr();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [9:0]  rs_fields;
        logic [11:0] imm;
        logic [4:0]  opc;
        kind      = 4'(take_bits(4));
        f3        = 3'(take_bits(3));
        rd        = 5'(take_bits(5));
        rs_fields = 10'(take_bits(10));
        rs1_val_i = take_bits(32);
        rs2_val_i = take_bits(32);
        if (kind < 4) begin  // register-register alu
            if ((f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SRL_SRA) &&
                take_bits(1) != 0) begin
                instr_i = {rv_isa_pkg::FUNCT7_ALT, rs_fields, f3, rd, rv_isa_pkg::OPC_OP, 2'b11};
            end else begin
                instr_i = {7'h00, rs_fields, f3, rd, rv_isa_pkg::OPC_OP, 2'b11};
            end
        end else if (kind < 7) begin
            imm = 12'(take_bits(12));
            if (f3 == rv_isa_pkg::F3_SLL) imm[11:5] = '0;
            if (f3 == rv_isa_pkg::F3_SRL_SRA) begin
                imm[11:5] = (take_bits(1) != 0) ? rv_isa_pkg::FUNCT7_ALT : 7'h00;
            end
            instr_i = {imm, rs_fields[4:0], f3, rd, rv_isa_pkg::OPC_OP_IMM, 2'b11};
        end else if (kind == 7) begin
            instr_i = {20'(take_bits(20)), rd, rv_isa_pkg::OPC_LUI, 2'b11};
        end else if (kind == 8) begin
            opc = 5'(take_bits(5));
            if (opc == rv_isa_pkg::OPC_OP || opc == rv_isa_pkg::OPC_OP_IMM ||
                opc == rv_isa_pkg::OPC_LUI) begin
                opc = opc ^ 5'b10000;  // move off a supported opcode
            end
            instr_i = {25'(take_bits(25)), opc, 2'b11};
        end else if (kind < 12) begin
            instr_i = {rv_isa_pkg::FUNCT7_MULDIV, rs_fields, 1'b0, f3[1:0], rd,
                       rv_isa_pkg::OPC_OP, 2'b11};
        end else begin
            div_count++;
            if (div_count % 5 == 0) begin
                if (take_bits(1) != 0) begin
                    rs2_val_i = '0;
                end else begin
                    rs1_val_i = 32'h8000_0000;
                    rs2_val_i = '1;
                end
            end
            instr_i = {rv_isa_pkg::FUNCT7_MULDIV, rs_fields, 1'b1, f3[1:0], rd,
                       rv_isa_pkg::OPC_OP, 2'b11};
        end
    endtask

    task automatic check_result();
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        if (out_valid_o) begin
            assert (exp_data_q.size() != 0) else begin
                $display("result for rd %0d at %0d ns has no instruction outstanding",
                         out_rd_o, $time);
                abort_run();
            end
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (out_rd_o == exp_rd && out_data_o == exp_data) else begin
                $display("error: %0d ns: got rd %0d data %08h, expected rd %0d data %08h",
                         $time, out_rd_o, out_data_o, exp_rd, exp_data);
                abort_run();
            end
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: run not finished after %0d cycles", cycle_count);
            abort_run();
        end
    end

    initial begin
        lfsr_state = LFSR_SEED;
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        in_valid_i = 1'b0;
        instr_i    = '0;
        rs1_val_i  = '0;
        rs2_val_i  = '0;
        n_accepted = 0;
        div_count  = 0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        repeat (4) begin  // idle after reset
            @(negedge clk_i);
            assert (!out_valid_o && in_ready_o) else begin
                $display("idle unit after reset shows out_valid_o %b and in_ready_o %b",
                         out_valid_o, in_ready_o);
                abort_run();
            end
        end

        while (n_accepted < NUM_INSTR || exp_data_q.size() != 0) begin
            @(negedge clk_i);
            check_result();
            took = in_valid_i && in_ready_o;  // transfer on the coming edge
            if (took) begin
                exp_rd_q.push_back(model_rd(instr_i));
                exp_data_q.push_back(model_result(instr_i, rs1_val_i, rs2_val_i));
                n_accepted++;
            end
            @(posedge clk_i);
            #1;
            if (!in_valid_i || took) begin  // a waiting instruction stays put
                if (n_accepted < NUM_INSTR && take_bits(2) != 0) begin
                    make_instr();
                    in_valid_i = 1'b1;
                end else begin
                    in_valid_i = 1'b0;
                end
            end
        end

        repeat (5) begin  // no stray results
            @(negedge clk_i);
            check_result();
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
